// ==== common/lock_ctrl_pkg.sv ====
package lock_ctrl_pkg;

	import lock_data_pkg::*;

	////////////////////
	// control panel set
	////////////////////

	// whole set moves as one 96 bit word
	typedef struct packed {
		sample_t   setpoint; // subtracted from every sample
		gain_t     kp;       // proportional gain
		gain_t     ki;       // integral gain
		gain_t     kd;       // derivative gain
		out_word_t out_max;  // upper clamp
		out_word_t out_min;  // lower clamp
		out_word_t out_init; // output while unlocked
		mult_t     mult;     // pid sum scaling
	} lock_params_t;

	////////////////////
	// preprocessor fsm
	////////////////////

	typedef enum logic [1:0] {
		st_idle,    // wait for a sum strobe
		st_compute, // let the datapath settle
		st_send,    // output valid high
		st_done     // latch previous output
	} opp_state_t;

endpackage

// ==== common/lock_data_pkg.sv ====
`include "lock_defs.svh"

package lock_data_pkg;

	////////////////////
	// scalar types
	////////////////////

	typedef logic signed [`LOCK_W_SAMPLE-1:0] sample_t;   // adc side sample
	typedef logic signed [`LOCK_W_SUM-1:0]    pid_sum_t;  // filter output
	typedef logic signed [`LOCK_W_OUT-1:0]    out_word_t; // actuator word
	typedef logic        [`LOCK_W_MLT-1:0]    mult_t;     // unsigned scale
	typedef logic signed [`LOCK_W_GAIN-1:0]   gain_t;     // signed gain

	////////////////////
	// strobed beats
	////////////////////

	typedef struct packed {
		logic    valid; // one cycle strobe
		sample_t data;
	} sample_beat_t;

	typedef struct packed {
		logic     valid;
		pid_sum_t data;
	} sum_beat_t;

	typedef struct packed {
		logic      valid;
		out_word_t data; // only meaningful with valid
	} out_beat_t;

endpackage

// ==== common/lock_defs.svh ====
`ifndef LOCK_DEFS_SVH
`define LOCK_DEFS_SVH

////////////////////
// datapath widths
////////////////////

`define LOCK_W_SAMPLE     16       // error detector sample
`define LOCK_W_SUM        32       // pid sum
`define LOCK_W_OUT        16       // actuator word
`define LOCK_W_MLT        8        // output multiplier
`define LOCK_W_GAIN       8        // p, i and d gains
`define LOCK_COMP_LATENCY 1        // cycles spent in st_compute

////////////////////
// parameter bank reset values
////////////////////

`define LOCK_MAX_INIT     16000    // upper output bound
`define LOCK_MIN_INIT     (-16000) // lower output bound
`define LOCK_OUT_INIT     0        // output while unlocked
`define LOCK_MULT_INIT    1        // unity scaling

`endif

// ==== hdl/lock_top.sv ====
`timescale 1ns/1ps

module lock_top
	import lock_data_pkg::*, lock_ctrl_pkg::*;
(
	input  logic         clk_in,
	input  logic         reset_in,
	input  sample_beat_t sample_in, // error detector stream
	input  logic         lock_en,   // closes the loop
	input  lock_params_t params_in, // staged panel values
	input  logic         update_en, // arms update
	input  logic         update,    // load strobe
	output out_beat_t    data_out   // four cycles after sample
);

lock_params_t params;        // active parameter set
logic         params_loaded; // realign pulse to both cores
sum_beat_t    sum_beat;      // pid filter to preprocessor

////////////////////
// blocks
////////////////////

param_bank u_param_bank (
	.clk_in        (clk_in),
	.reset_in      (reset_in),
	.params_in     (params_in),
	.update_en     (update_en),
	.update        (update),
	.params        (params),
	.params_loaded (params_loaded)
);

pid_filter u_pid_filter (
	.clk_in        (clk_in),
	.reset_in      (reset_in),
	.sample        (sample_in),
	.lock_en       (lock_en),
	.params        (params),
	.params_loaded (params_loaded),
	.sum_beat      (sum_beat)       // two cycle latency
);

output_preprocessor u_output_preprocessor (
	.clk_in        (clk_in),
	.reset_in      (reset_in),
	.sum_beat      (sum_beat),
	.lock_en       (lock_en),
	.params        (params),
	.params_loaded (params_loaded),
	.data_out      (data_out)       // busy for four cycles per beat
);

endmodule

// ==== hdl/param_bank.sv ====
`timescale 1ns/1ps

`include "lock_defs.svh"

module param_bank
	import lock_data_pkg::*, lock_ctrl_pkg::*;
(
	input  logic         clk_in,
	input  logic         reset_in,
	input  lock_params_t params_in,     // staged panel values
	input  logic         update_en,     // arms the update strobe
	input  logic         update,        // load strobe
	output lock_params_t params,        // active set
	output logic         params_loaded  // one cycle after a load
);

////////////////////
// reset set
////////////////////

localparam lock_params_t params_reset = '{
	setpoint: sample_t'(0),
	kp:       gain_t'(0),
	ki:       gain_t'(0),
	kd:       gain_t'(0),
	out_max:  out_word_t'(`LOCK_MAX_INIT),
	out_min:  out_word_t'(`LOCK_MIN_INIT),
	out_init: out_word_t'(`LOCK_OUT_INIT),
	mult:     mult_t'(`LOCK_MULT_INIT)
};

logic load; // qualified update

assign load = update & update_en; // strobe ignored unless armed

////////////////////
// registers
////////////////////

always_ff @(posedge clk_in) begin
	if (reset_in) begin
		params        <= params_reset;
		params_loaded <= 1'b0;
	end else begin
		params_loaded <= load; // cores realign on this pulse
		if (load) begin
			params <= params_in; // all fields at once
		end
	end
end

endmodule

// ==== list.f ====
+incdir+common
common/lock_data_pkg.sv
common/lock_ctrl_pkg.sv
hdl/param_bank.sv
pid_filter/pid_filter.sv
output_preprocessor/output_preprocessor.sv
hdl/lock_top.sv
sim/lock_assert.sv
sim/lock_tb.sv

// ==== output_preprocessor/output_preprocessor.sv ====
`timescale 1ns/1ps

`include "lock_defs.svh"

module output_preprocessor
	import lock_data_pkg::*, lock_ctrl_pkg::*;
(
	input  logic         clk_in,
	input  logic         reset_in,
	input  sum_beat_t    sum_beat,      // from pid filter
	input  logic         lock_en,       // low forces out_init
	input  lock_params_t params,        // bounds, init and multiplier
	input  logic         params_loaded, // reload previous output
	output out_beat_t    data_out       // actuator beat
);

////////////////////
// widths
////////////////////

localparam int w_prod = `LOCK_W_SUM + `LOCK_W_MLT + 1; // sum times zero extended mult
localparam int w_acc  = w_prod + 1;                    // plus previous output
localparam int w_cnt  = 8;

localparam logic [w_cnt-1:0] cnt_last = w_cnt'(`LOCK_COMP_LATENCY - 1);

opp_state_t              state;
opp_state_t              state_next;
logic [w_cnt-1:0]        cnt;        // cycles spent in st_compute
pid_sum_t                sum_r;      // sum captured in st_idle
out_word_t               out_prev;   // last sent output
logic signed [w_prod-1:0] stage_mult;
logic signed [w_acc-1:0] stage_add;
logic signed [w_acc-1:0] stage_sel;
logic signed [w_acc-1:0] stage_max;
logic signed [w_acc-1:0] stage_min;
out_word_t               out_next;   // clamped result

////////////////////
// datapath
////////////////////

assign stage_mult = sum_r * $signed({1'b0, params.mult}); // mult treated as unsigned
assign stage_add  = stage_mult + out_prev;                // accumulate onto last output
assign stage_sel  = lock_en ? stage_add : params.out_init;
assign stage_max  = (stage_sel > params.out_max) ? params.out_max : stage_sel;
assign stage_min  = (stage_max < params.out_min) ? params.out_min : stage_max; // min wins
assign out_next   = stage_min[`LOCK_W_OUT-1:0]; // in range after clamp

assign data_out = '{valid: (state == st_send), data: out_next};

always_ff @(posedge clk_in) begin
	if (state == st_idle && sum_beat.valid) begin
		sum_r <= sum_beat.data; // busy states drop the beat
	end
end

always_ff @(posedge clk_in) begin
	if (reset_in) begin
		out_prev <= out_word_t'(`LOCK_OUT_INIT);
	end else if (params_loaded) begin
		out_prev <= params.out_init; // restart from new init
	end else if (state == st_done) begin
		out_prev <= out_next;
	end
end

////////////////////
// fsm
////////////////////

always_ff @(posedge clk_in) begin
	if (reset_in) begin
		state <= st_idle;
	end else begin
		state <= state_next;
	end
end

always_ff @(posedge clk_in) begin
	if (reset_in) begin
		cnt <= '0;
	end else if (state != st_compute) begin
		cnt <= '0; // zero on entry to compute
	end else begin
		cnt <= cnt + 1'b1;
	end
end

always_comb begin
	state_next = state;
	case (state)
		st_idle: begin
			if (sum_beat.valid) begin
				state_next = st_compute;
			end
		end
		st_compute: begin
			if (cnt == cnt_last) begin
				state_next = st_send; // latency reached
			end
		end
		st_send: begin
			state_next = st_done; // valid for one cycle
		end
		st_done: begin
			state_next = st_idle;
		end
		default: begin
			state_next = st_idle;
		end
	endcase
end

endmodule

// ==== pid_filter/pid_filter.sv ====
`timescale 1ns/1ps

`include "lock_defs.svh"

module pid_filter
	import lock_data_pkg::*, lock_ctrl_pkg::*;
(
	input  logic         clk_in,
	input  logic         reset_in,
	input  sample_beat_t sample,        // error detector beat
	input  logic         lock_en,       // low holds integrator at zero
	input  lock_params_t params,        // setpoint and gains
	input  logic         params_loaded, // new set, restart history
	output sum_beat_t    sum_beat       // two cycles after sample
);

////////////////////
// widths
////////////////////

localparam int w_err  = `LOCK_W_SAMPLE + 1;            // sample minus setpoint
localparam int w_diff = w_err + 1;                     // error minus previous error
localparam int w_wide = `LOCK_W_SUM + `LOCK_W_GAIN + 2; // i term plus carry room

localparam logic signed [w_wide-1:0] sum_max =
	{{(w_wide-`LOCK_W_SUM+1){1'b0}}, {(`LOCK_W_SUM-1){1'b1}}};
localparam logic signed [w_wide-1:0] sum_min = ~sum_max;

// clip a wide value into the 32 bit sum range
function automatic pid_sum_t sat_sum(input logic signed [w_wide-1:0] v);
	pid_sum_t r;
	if (v > sum_max) begin
		r = sum_max[`LOCK_W_SUM-1:0];
	end else if (v < sum_min) begin
		r = sum_min[`LOCK_W_SUM-1:0];
	end else begin
		r = v[`LOCK_W_SUM-1:0];
	end
	return r;
endfunction

logic                     clear;     // wipe integrator and history
logic signed [w_err-1:0]  err_now;   // combinational error
logic signed [w_err-1:0]  err_r;     // stage one error
logic signed [w_err-1:0]  err_prev;  // error of last sample
logic signed [w_diff-1:0] diff_now;
logic signed [w_diff-1:0] diff_r;    // stage one difference
logic                     valid_r;   // stage one strobe
pid_sum_t                 acc;       // integrator
pid_sum_t                 acc_next;
logic signed [w_wide-1:0] acc_wide;
logic signed [w_wide-1:0] p_term;
logic signed [w_wide-1:0] i_term;
logic signed [w_wide-1:0] d_term;
logic signed [w_wide-1:0] sum_wide;
pid_sum_t                 sum_r;     // stage two sum
logic                     sum_valid; // stage two strobe

assign clear = ~lock_en | params_loaded;

////////////////////
// stage one
////////////////////

assign err_now  = sample.data - params.setpoint; // 17 bits, no wrap
assign diff_now = err_now - err_prev;

always_ff @(posedge clk_in) begin
	if (reset_in) begin
		valid_r <= 1'b0;
	end else begin
		valid_r <= sample.valid;
	end
end

always_ff @(posedge clk_in) begin
	if (sample.valid) begin
		err_r  <= err_now;
		diff_r <= diff_now;
	end
end

always_ff @(posedge clk_in) begin
	if (reset_in || clear) begin
		err_prev <= '0;
	end else if (sample.valid) begin
		err_prev <= err_now; // history for the d term
	end
end

////////////////////
// stage two
////////////////////

assign acc_wide = acc + err_r;         // sign extended before add
assign acc_next = sat_sum(acc_wide);   // integrator never wraps
assign p_term   = err_r * params.kp;
assign i_term   = acc_next * params.ki; // uses the updated integral
assign d_term   = diff_r * params.kd;
assign sum_wide = p_term + i_term + d_term;

always_ff @(posedge clk_in) begin
	if (reset_in || clear) begin
		acc <= '0;
	end else if (valid_r) begin
		acc <= acc_next;
	end
end

always_ff @(posedge clk_in) begin
	if (reset_in) begin
		sum_valid <= 1'b0;
	end else begin
		sum_valid <= valid_r;
	end
end

always_ff @(posedge clk_in) begin
	if (valid_r) begin
		sum_r <= sat_sum(sum_wide);
	end
end

assign sum_beat = '{valid: sum_valid, data: sum_r};

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module lock_tb -f list.f -o lock_sim
./obj_dir/lock_sim

// ==== sim/lock_assert.sv ====
`timescale 1ns/1ps

module lock_assert
	import lock_data_pkg::*, lock_ctrl_pkg::*;
(
	input logic         clk_in,
	input logic         reset_in,
	input sample_beat_t sample_in, // top level sample beat
	input out_beat_t    data_out,  // top level output beat
	input lock_params_t params     // active set inside the top
);

logic [7:0] gap; // cycles since the last sample strobe

always_ff @(posedge clk_in) begin
	if (reset_in) begin
		gap <= 8'hff;
	end else if (sample_in.valid) begin
		gap <= 8'd1;
	end else if (gap != 8'hff) begin
		gap <= gap + 8'd1; // saturates
	end
end

////////////////////
// properties
////////////////////

a_single_strobe: assert property (@(posedge clk_in) disable iff (reset_in)
	data_out.valid |=> !data_out.valid)
	else $error("data_out valid high in two consecutive cycles");

a_latency: assert property (@(posedge clk_in) disable iff (reset_in)
	(sample_in.valid && gap >= 8'd6) |-> ##4 data_out.valid)
	else $error("no output strobe four cycles after a spaced sample");

a_in_bounds: assert property (@(posedge clk_in) disable iff (reset_in)
	data_out.valid |-> ($signed(data_out.data) <= $signed(params.out_max)
		&& $signed(data_out.data) >= $signed(params.out_min)))
	else $error("output word outside out_min and out_max");

endmodule

bind lock_top lock_assert u_lock_assert (
	.clk_in    (clk_in),
	.reset_in  (reset_in),
	.sample_in (sample_in),
	.data_out  (data_out),
	.params    (params)
);

// ==== sim/lock_tb.sv ====
`timescale 1ns/1ps

`include "lock_defs.svh"

module lock_tb
	import lock_data_pkg::*, lock_ctrl_pkg::*;
();

localparam int     n_samples    = 7 + 6 + 45 + 6 + 8;      // off, p only, pid, clamp, update
localparam int     limit_cycles = n_samples * 10 + 200;    // watchdog budget
localparam longint sum_hi       = 2147483647;              // 32 bit sum range
localparam longint sum_lo       = -sum_hi - 1;

logic         clk_in;
logic         reset_in;
sample_beat_t sample_in;
logic         lock_en;
lock_params_t params_in;
logic         update_en;
logic         update;
out_beat_t    data_out;

int           seed;              // $random state
int           sent_count = 0;    // samples driven
int           out_count  = 0;    // strobes seen
out_word_t    exp_q[$];          // predicted outputs in order
lock_params_t m_params;          // mirrored active set
longint       m_acc;             // mirrored integrator
longint       m_err_prev;        // mirrored error history
longint       m_out_prev;        // mirrored previous output

lock_top DUT (
	.clk_in    (clk_in),
	.reset_in  (reset_in),
	.sample_in (sample_in),
	.lock_en   (lock_en),
	.params_in (params_in),
	.update_en (update_en),
	.update    (update),
	.data_out  (data_out)
);

////////////////////
// model
////////////////////

function automatic lock_params_t build_params(input int sp, input int kp, input int ki,
	input int kd, input int mx, input int mn, input int ini, input int ml);
	lock_params_t p;
	p.setpoint = sample_t'(sp);
	p.kp       = gain_t'(kp);
	p.ki       = gain_t'(ki);
	p.kd       = gain_t'(kd);
	p.out_max  = out_word_t'(mx);
	p.out_min  = out_word_t'(mn);
	p.out_init = out_word_t'(ini);
	p.mult     = mult_t'(ml);
	return p;
endfunction

function automatic int rand_range(input int lo, input int hi);
	int r;
	r = $random(seed);
	r = r & 32'h7fffffff; // keep it positive
	return lo + (r % (hi - lo + 1));
endfunction

function automatic lock_params_t random_params();
	int v[8];
	v[0] = rand_range(-1000, 1000);   // setpoint
	v[1] = rand_range(-8, 8);         // kp
	v[2] = rand_range(-4, 4);         // ki
	v[3] = rand_range(-8, 8);         // kd
	v[4] = rand_range(2000, 16000);   // upper bound
	v[5] = rand_range(-16000, -2000); // lower bound
	v[6] = rand_range(-1000, 1000);   // init value
	v[7] = rand_range(1, 4);          // multiplier
	return build_params(v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
endfunction

function automatic longint saturate_sum(input longint v);
	if (v > sum_hi) begin
		return sum_hi;
	end
	if (v < sum_lo) begin
		return sum_lo;
	end
	return v;
endfunction

// upper bound first and the lower bound wins
function automatic out_word_t clamp_word(input longint v);
	longint c;
	c = v;
	if (c > longint'($signed(m_params.out_max))) begin
		c = longint'($signed(m_params.out_max));
	end
	if (c < longint'($signed(m_params.out_min))) begin
		c = longint'($signed(m_params.out_min));
	end
	return out_word_t'(c);
endfunction

// expected actuator word for one sample and advance of the mirrored state
function automatic out_word_t predict_output(input sample_t s, input logic locked);
	longint    err;
	longint    diff;
	longint    acc_n;
	longint    sum;
	out_word_t res;
	err = longint'(s) - longint'($signed(m_params.setpoint));
	if (!locked) begin
		m_acc      = 0;                                        // integrator held clear
		m_err_prev = 0;
		res        = clamp_word(longint'($signed(m_params.out_init)));
	end else begin
		diff       = err - m_err_prev;
		m_err_prev = err;
		acc_n      = saturate_sum(m_acc + err);                // i term sees new integral
		m_acc      = acc_n;
		sum        = saturate_sum(err * longint'($signed(m_params.kp))
			+ acc_n * longint'($signed(m_params.ki))
			+ diff * longint'($signed(m_params.kd)));
		res        = clamp_word(sum * longint'(m_params.mult) + m_out_prev); // mult unsigned
	end
	m_out_prev = longint'(res);
	return res;
endfunction

////////////////////
// checks
////////////////////

task automatic check_out(input string name, input out_word_t got, input out_word_t expected);
	if (got !== expected) begin
		$display("ERR %s got %h expected %h", name, got, expected);
		$display("tests failed");
		$fatal(1);
	end
endtask

task automatic check_count(input string name, input int got, input int expected);
	if (got !== expected) begin
		$display("ERR %s got %h expected %h", name, got, expected);
		$display("tests failed");
		$fatal(1);
	end
endtask

task automatic report_failure(input string what);
	$display("%s", what);
	$display("tests failed");
	$fatal(1);
endtask

////////////////////
// stimulus tasks
////////////////////

// one strobe and seven idle cycles before the next sample
task automatic send_sample(input sample_t s);
	@(negedge clk_in);
	sample_in = '{valid: 1'b1, data: s};
	exp_q.push_back(predict_output(s, lock_en));
	sent_count = sent_count + 1;
	@(negedge clk_in);
	sample_in.valid = 1'b0;
	repeat (6) @(negedge clk_in);
endtask

task automatic apply_update(input lock_params_t p, input logic en);
	@(negedge clk_in);
	params_in = p;
	update_en = en;
	update    = 1'b1;
	@(negedge clk_in);
	update    = 1'b0;
	update_en = 1'b0;
	if (en) begin
		m_params   = p;
		m_acc      = 0;                    // params_loaded clears history
		m_err_prev = 0;
		m_out_prev = longint'($signed(p.out_init)); // raw init without clamp
	end
	repeat (2) @(negedge clk_in);
endtask

task automatic set_lock(input logic en);
	@(negedge clk_in);
	lock_en = en;
	if (!en) begin
		m_acc      = 0;
		m_err_prev = 0;
	end
	@(negedge clk_in);
endtask

////////////////////
// processes
////////////////////

initial begin
	clk_in = 1'b0;
	forever #50 clk_in = ~clk_in; // 100 ns period
end

// every strobe against the next prediction
always @(posedge clk_in) begin
	if (!reset_in && data_out.valid) begin
		out_count = out_count + 1;
		if (exp_q.size() == 0) begin
			report_failure("output strobe arrived with no sample outstanding");
		end else begin
			check_out("data_out.data", data_out.data, exp_q.pop_front());
		end
	end
end

initial begin : watchdog
	repeat (limit_cycles) @(posedge clk_in);
	$display("timeout after %0d cycles, the run did not finish", limit_cycles);
	$display("tests failed");
	$fatal(1);
end

initial begin : stimulus
	lock_params_t p;
	seed       = 71098;
	reset_in   = 1'b1;
	sample_in  = '0;
	lock_en    = 1'b0;
	params_in  = build_params(0, 0, 0, 0, `LOCK_MAX_INIT, `LOCK_MIN_INIT, `LOCK_OUT_INIT,
		`LOCK_MULT_INIT);
	update_en  = 1'b0;
	update     = 1'b0;
	m_params   = params_in;                 // bank comes out of reset with these
	m_acc      = 0;
	m_err_prev = 0;
	m_out_prev = `LOCK_OUT_INIT;
	repeat (3) @(posedge clk_in);
	@(negedge clk_in);
	reset_in = 1'b0;

	// lock disabled so the output stays at init
	for (int i = 0; i < 4; i++) begin
		send_sample(sample_t'(rand_range(-32768, 32767)));
	end
	apply_update(build_params(0, 3, 1, 2, 300, -300, 500, 1), 1'b1); // init above max
	for (int i = 0; i < 3; i++) begin
		send_sample(sample_t'(rand_range(-32768, 32767)));
	end

	// proportional only
	apply_update(build_params(100, 3, 0, 0, 16000, -16000, 0, 1), 1'b1);
	set_lock(1'b1);
	for (int i = 0; i < 6; i++) begin
		send_sample(sample_t'(rand_range(-500, 500)));
	end

	// full pid over three random sets
	for (int r = 0; r < 3; r++) begin
		apply_update(random_params(), 1'b1);
		for (int i = 0; i < 15; i++) begin
			send_sample(sample_t'(rand_range(-3000, 3000)));
		end
	end

	// large errors hit both bounds
	apply_update(build_params(0, 100, 0, 0, 16000, -16000, 0, 1), 1'b1);
	for (int i = 0; i < 3; i++) begin
		send_sample(sample_t'(30000));
	end
	for (int i = 0; i < 3; i++) begin
		send_sample(sample_t'(-30000));
	end

	// unarmed update ignored and armed one restarts from init
	p = build_params(-50, -5, 2, 1, 1000, -1000, 50, 2);
	apply_update(p, 1'b0);
	for (int i = 0; i < 3; i++) begin
		send_sample(sample_t'(rand_range(-100, 100)));
	end
	apply_update(p, 1'b1);
	for (int i = 0; i < 5; i++) begin
		send_sample(sample_t'(rand_range(-400, 400)));
	end

	repeat (10) @(posedge clk_in); // well past the 4 cycle output latency
	check_count("out_count", out_count, sent_count);
	$display("all tests passed");
	$finish;
end

endmodule
